// ==== Bender.yml ====
package:
  name: aes_core

sources:
  - target: rtl
    files:
      - src/aes_cfg_pkg.sv
      - src/aes_data_pkg.sv
      - src/aes_control_unit.sv
      - src/aes_key_expander.sv
      - src/aes_col_datapath.sv
      - src/aes_mode_unit.sv
      - src/aes_core_top.sv
  - target: test
    files:
      - tests/aes_core_tb.sv

// ==== filelist.f ====
src/aes_cfg_pkg.sv
src/aes_data_pkg.sv
src/aes_control_unit.sv
src/aes_key_expander.sv
src/aes_col_datapath.sv
src/aes_mode_unit.sv
src/aes_core_top.sv
tests/aes_core_tb.sv

// ==== src/aes_cfg_pkg.sv ====
package aes_cfg_pkg;

	// ========================================================================
	// Modes and FSM encodings
	// ========================================================================

	// Block cipher modes, encodings kept from the register map
	typedef enum logic [1:0]
	{
		ECB = 2'b00,
		CTR = 2'b10
	} aes_mode_t;

	// Control FSM states
	typedef enum logic [2:0]
	{
		IDLE,
		ROUND0,
		ROUND_KEY,
		ROUND_COL,
		READY
	} ctl_state_t;

	// Owner of the shared S-box in a given cycle
	typedef enum logic [0:0]
	{
		COLUMN     = 1'b0,
		G_FUNCTION = 1'b1
	} sbox_src_t;

	// ========================================================================
	// Sizes
	// ========================================================================

	localparam int NUM_ROUNDS  = 10;
	// Result credits granted by the sink after reset
	localparam int OUT_CREDITS = 2;

	typedef logic [3:0] round_t;
	typedef logic [1:0] col_idx_t;
	typedef logic [$clog2(OUT_CREDITS + 1) - 1:0] credit_t;

	// Selector bundle from the FSM to datapath and key expander
	typedef struct packed
	{
		sbox_src_t sbox_src;
		col_idx_t  col;
		round_t    round;
		logic      last_round;
		logic      load_state;
		logic      col_en;
		logic      commit_state;
		logic      key_en;
		logic      key_word_en;
		logic      key_init;
	} ctl_bus_t;

endpackage

// ==== src/aes_col_datapath.sv ====
`timescale 1ns/1ps

module aes_col_datapath
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  aes_cfg_pkg::ctl_bus_t   ctl,
	input  aes_data_pkg::aes_block_t blk,
	input  aes_data_pkg::aes_word_t rk_word,
	input  aes_data_pkg::key_t      rk_block,
	input  aes_data_pkg::aes_word_t g_word,
	output aes_data_pkg::aes_word_t sub_word,
	output aes_data_pkg::aes_block_t result
);
	import aes_cfg_pkg::*;
	import aes_data_pkg::*;

	aes_block_t state_q;
	aes_block_t next_q;
	aes_word_t  sb_in;
	aes_word_t  new_col;

	// ShiftRows pick, row r of column c from column c+r
	function automatic aes_word_t shift_col(aes_block_t s, col_idx_t c);
		aes_word_t w;
		col_idx_t  src;
		for (int r = 0; r < 4; r++)
		begin
			src = c + col_idx_t'(r);
			w[31 - 8 * r -: 8] = s[127 - 32 * int'(src) - 8 * r -: 8];
		end
		return w;
	endfunction

	// MixColumns on one column
	function automatic aes_word_t mix_col(aes_word_t w);
		aes_byte_t a [4];
		aes_byte_t t;
		aes_word_t m;
		for (int i = 0; i < 4; i++)
			a[i] = w[31 - 8 * i -: 8];
		t = a[0] ^ a[1] ^ a[2] ^ a[3];
		// b_i = a_i ^ t ^ 2(a_i ^ a_i+1)
		for (int i = 0; i < 4; i++)
			m[31 - 8 * i -: 8] = a[i] ^ t ^ gf_xtime(a[i] ^ a[(i + 1) % 4]);
		return m;
	endfunction

	// ========================================================================
	// Shared S-box, four byte lanes
	// ========================================================================

	always_comb
	begin
		sb_in = (ctl.sbox_src == G_FUNCTION) ? g_word : shift_col(state_q, ctl.col);
		for (int i = 0; i < 4; i++)
			sub_word[31 - 8 * i -: 8] = aes_sbox(sb_in[31 - 8 * i -: 8]);
	end

	// No MixColumns in the last round
	assign new_col = (ctl.last_round ? sub_word : mix_col(sub_word)) ^ rk_word;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q <= '0;
			next_q  <= '0;
		end
		else
		begin
			// Round 0 AddRoundKey on the whole block
			if (ctl.load_state)
				state_q <= blk ^ rk_block;
			// Column 3 goes straight in with the commit
			else if (ctl.commit_state)
				state_q <= {next_q[127:32], new_col};
			if (ctl.col_en)
				next_q[127 - 32 * int'(ctl.col) -: 32] <= new_col;
		end
	end

	assign result = state_q;

endmodule

// ==== src/aes_control_unit.sv ====
`timescale 1ns/1ps

module aes_control_unit
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	output aes_cfg_pkg::ctl_bus_t ctl,
	output logic                 done
);
	import aes_cfg_pkg::*;

	ctl_state_t state;
	ctl_state_t state_nx;
	round_t     rnd;
	col_idx_t   col_cnt;
	logic       last_rnd;
	logic       col_last;

	assign last_rnd = (rnd == round_t'(NUM_ROUNDS));
	assign col_last = (col_cnt == 2'd3);

	// ========================================================================
	// State register and next state
	// ========================================================================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_nx;
	end

	always_comb
	begin
		state_nx = state;
		case (state)
			IDLE:
				if (start)
					state_nx = ROUND0;
			// Whole-block AddRoundKey, then into round 1
			ROUND0:
				state_nx = ROUND_KEY;
			ROUND_KEY:
				state_nx = ROUND_COL;
			// Four columns per round
			ROUND_COL:
				if (col_last)
					state_nx = last_rnd ? READY : ROUND_KEY;
			READY:
				state_nx = IDLE;
			default:
				state_nx = IDLE;
		endcase
	end

	// ========================================================================
	// Round and column counters
	// ========================================================================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rnd     <= '0;
			col_cnt <= '0;
		end
		else
		begin
			case (state)
				IDLE:
					rnd <= '0;
				ROUND0:
					rnd <= round_t'(1);
				ROUND_KEY:
					col_cnt <= '0;
				ROUND_COL:
				begin
					col_cnt <= col_cnt + 2'd1;
					// Next round starts after column 3
					if (col_last && !last_rnd)
						rnd <= rnd + 4'd1;
				end
				default:
					col_cnt <= '0;
			endcase
		end
	end

	// ========================================================================
	// Selector outputs
	// ========================================================================

	always_comb
	begin
		ctl          = '0;
		ctl.sbox_src = COLUMN;
		ctl.col      = col_cnt;
		ctl.round    = rnd;
		case (state)
			// Round key words reload from the master key
			IDLE:
				ctl.key_init = start;
			ROUND0:
				ctl.load_state = 1'b1;
			// G function owns the S-box
			ROUND_KEY:
			begin
				ctl.sbox_src = G_FUNCTION;
				ctl.key_en   = 1'b1;
			end
			ROUND_COL:
			begin
				ctl.col_en       = 1'b1;
				ctl.last_round   = last_rnd;
				ctl.key_word_en  = !col_last;
				ctl.commit_state = col_last;
			end
			default:
				ctl.sbox_src = COLUMN;
		endcase
	end

	// Result register holds the ciphertext here
	assign done = (state == READY);

endmodule

// ==== src/aes_core_top.sv ====
`timescale 1ns/1ps

module aes_core_top
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     key_load,
	input  aes_data_pkg::key_t       key,
	input  aes_cfg_pkg::aes_mode_t   mode,
	input  logic                     iv_load,
	input  aes_data_pkg::aes_block_t iv,
	input  aes_data_pkg::blk_in_t    in_blk,
	output logic                     in_credit,
	output aes_data_pkg::blk_out_t   out_blk,
	input  logic                     out_credit
);
	import aes_cfg_pkg::*;
	import aes_data_pkg::*;

	// ========================================================================
	// Internal wiring
	// ========================================================================

	logic       start;
	logic       done;
	ctl_bus_t   ctl;
	aes_block_t blk;
	aes_block_t result;
	aes_word_t  sub_word;
	aes_word_t  g_word;
	aes_word_t  rk_word;
	key_t       rk_block;

	// Block capture, CTR and credits
	aes_mode_unit u_aes_mode_unit
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.mode       (mode),
		.key_load   (key_load),
		.iv_load    (iv_load),
		.iv         (iv),
		.in_blk     (in_blk),
		.in_credit  (in_credit),
		.out_blk    (out_blk),
		.out_credit (out_credit),
		.start      (start),
		.blk        (blk),
		.done       (done),
		.result     (result)
	);

	aes_control_unit u_aes_control_unit
	(
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.ctl   (ctl),
		.done  (done)
	);

	// Key schedule borrows the datapath S-box
	aes_key_expander u_aes_key_expander
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.key_load (key_load),
		.key      (key),
		.ctl      (ctl),
		.sub_word (sub_word),
		.g_word   (g_word),
		.rk_word  (rk_word),
		.rk_block (rk_block)
	);

	aes_col_datapath u_aes_col_datapath
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.ctl      (ctl),
		.blk      (blk),
		.rk_word  (rk_word),
		.rk_block (rk_block),
		.g_word   (g_word),
		.sub_word (sub_word),
		.result   (result)
	);

endmodule

// ==== src/aes_data_pkg.sv ====
package aes_data_pkg;

	// ========================================================================
	// Data types
	// ========================================================================

	typedef logic [7:0]   aes_byte_t;
	// One state column, byte 0 in the top bits
	typedef logic [31:0]  aes_word_t;
	// Byte 0 of the block in bits 127:120
	typedef logic [127:0] aes_block_t;
	typedef logic [127:0] key_t;

	typedef struct packed
	{
		aes_block_t data;
		logic       valid;
	} blk_in_t;

	typedef struct packed
	{
		aes_block_t data;
		logic       valid;
	} blk_out_t;

	// ========================================================================
	// S-box table and GF(2^8) helpers
	// ========================================================================

	// Forward S-box, entry 0 in the top byte
	localparam logic [2047:0] SBOX_TABLE =
	{
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	function automatic aes_byte_t aes_sbox(aes_byte_t b);
		return SBOX_TABLE[2047 - 8 * int'(b) -: 8];
	endfunction

	// Multiply by x, reduce by x^8 + x^4 + x^3 + x + 1
	function automatic aes_byte_t gf_xtime(aes_byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

endpackage

// ==== src/aes_key_expander.sv ====
`timescale 1ns/1ps

module aes_key_expander
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   key_load,
	input  aes_data_pkg::key_t     key,
	input  aes_cfg_pkg::ctl_bus_t  ctl,
	input  aes_data_pkg::aes_word_t sub_word,
	output aes_data_pkg::aes_word_t g_word,
	output aes_data_pkg::aes_word_t rk_word,
	output aes_data_pkg::key_t     rk_block
);
	import aes_cfg_pkg::*;
	import aes_data_pkg::*;

	key_t key_q;
	// Working round key, word 0 in the top bits
	key_t rk_q;

	// Rcon for round r, doubling from 01
	function automatic aes_byte_t rcon(round_t r);
		aes_byte_t rc;
		rc = 8'h01;
		for (int i = 1; i < NUM_ROUNDS; i++)
		begin
			if (i < int'(r))
				rc = gf_xtime(rc);
		end
		return rc;
	endfunction

	// RotWord of word 3 goes to the shared S-box
	assign g_word   = {rk_q[23:0], rk_q[31:24]};
	assign rk_word  = rk_q[127 - 32 * int'(ctl.col) -: 32];
	assign rk_block = rk_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			key_q <= '0;
			rk_q  <= '0;
		end
		else
		begin
			if (key_load)
				key_q <= key;
			if (ctl.key_init)
				rk_q <= key_q;
			// Word 0 takes SubWord(RotWord(w3)) and Rcon
			else if (ctl.key_en)
				rk_q[127:96] <= rk_q[127:96] ^ sub_word ^ {rcon(ctl.round), 24'h0};
			// Word c+1 follows word c, one per column cycle
			else if (ctl.key_word_en)
				rk_q[95 - 32 * int'(ctl.col) -: 32] <=
					rk_q[95 - 32 * int'(ctl.col) -: 32] ^ rk_q[127 - 32 * int'(ctl.col) -: 32];
		end
	end

endmodule

// ==== src/aes_mode_unit.sv ====
`timescale 1ns/1ps

module aes_mode_unit
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  aes_cfg_pkg::aes_mode_t   mode,
	input  logic                     key_load,
	input  logic                     iv_load,
	input  aes_data_pkg::aes_block_t iv,
	input  aes_data_pkg::blk_in_t    in_blk,
	output logic                     in_credit,
	output aes_data_pkg::blk_out_t   out_blk,
	input  logic                     out_credit,
	output logic                     start,
	output aes_data_pkg::aes_block_t blk,
	input  logic                     done,
	input  aes_data_pkg::aes_block_t result
);
	import aes_cfg_pkg::*;
	import aes_data_pkg::*;

	aes_mode_t  mode_q;
	aes_block_t data_q;
	aes_block_t ctr_q;
	aes_block_t res_q;
	credit_t    out_cnt;
	logic       res_pend;
	logic       boot_q;
	logic       emit;

	// Result leaves only with sink credit
	assign emit = res_pend && (out_cnt != '0);

	// CTR encrypts the counter, ECB the data
	assign blk = (mode_q == CTR) ? ctr_q : data_q;

	assign out_blk.valid = emit;
	assign out_blk.data  = (mode_q == CTR) ? (res_q ^ data_q) : res_q;

	// ========================================================================
	// Control and credit state
	// ========================================================================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mode_q    <= ECB;
			start     <= 1'b0;
			res_pend  <= 1'b0;
			out_cnt   <= credit_t'(OUT_CREDITS);
			boot_q    <= 1'b1;
			in_credit <= 1'b0;
		end
		else
		begin
			if (key_load)
				mode_q <= mode;
			start <= in_blk.valid;
			if (done)
				res_pend <= 1'b1;
			else if (emit)
				res_pend <= 1'b0;
			out_cnt <= out_cnt + credit_t'(out_credit) - credit_t'(emit);
			// First credit right after reset, then one per handoff
			boot_q    <= 1'b0;
			in_credit <= boot_q | emit;
		end
	end

	// Block, counter and result payload
	always_ff @(posedge clk)
	begin
		if (in_blk.valid)
			data_q <= in_blk.data;
		if (done)
			res_q <= result;
		// Counter wraps modulo 2^128
		if (iv_load)
			ctr_q <= iv;
		else if (emit && (mode_q == CTR))
			ctr_q <= ctr_q + 128'd1;
	end

endmodule

// ==== tests/aes_core_tb.sv ====
`timescale 1ns/1ps

module aes_core_tb;
	import aes_cfg_pkg::*;
	import aes_data_pkg::*;

	localparam int CLK_PERIOD = 8;
	// Known vector, random ECB, CTR, back-pressure, reset
	localparam int NUM_BLOCKS = 32;

	logic       clk;
	logic       rst_n;
	logic       key_load;
	key_t       key;
	aes_mode_t  mode;
	logic       iv_load;
	aes_block_t iv;
	blk_in_t    in_blk;
	logic       in_credit;
	blk_out_t   out_blk;
	logic       out_credit;

	integer     seed = 32'hdf93_a85d;
	int         errors = 0;
	int         credits_held = 0;
	int         outstanding = 0;
	int         credits_owed = 0;
	int         valid_total = 0;
	int         returned_total = 0;
	int         sink_delay;
	logic       hold_credit = 1'b0;
	aes_block_t exp_q [$];
	string      name_q [$];
	key_t       cur_key = '0;
	aes_block_t ctr_model = '0;
	aes_block_t data_tmp;

	aes_core_top u_aes_core_top
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.key_load   (key_load),
		.key        (key),
		.mode       (mode),
		.iv_load    (iv_load),
		.iv         (iv),
		.in_blk     (in_blk),
		.in_credit  (in_credit),
		.out_blk    (out_blk),
		.out_credit (out_credit)
	);

	// ========================================================================
	// Reference model
	// ========================================================================

	// Whole-block AES-128, byte 0 in the top bits, column-major state
	function automatic aes_block_t aes_encrypt_ref(key_t k, aes_block_t pt);
		aes_byte_t  w [176];
		aes_byte_t  s [16];
		aes_byte_t  t [16];
		aes_byte_t  tmp [4];
		aes_byte_t  rc;
		aes_block_t ct;
		int         b;
		rc = 8'h01;
		for (int i = 0; i < 16; i++)
			w[i] = k[127 - 8 * i -: 8];
		// Key expansion, one word per step
		for (int i = 4; i < 44; i++)
		begin
			for (int j = 0; j < 4; j++)
				tmp[j] = w[4 * (i - 1) + j];
			// SubWord(RotWord) plus Rcon on every fourth word
			if (i % 4 == 0)
			begin
				for (int j = 0; j < 4; j++)
					tmp[j] = aes_sbox(w[4 * (i - 1) + (j + 1) % 4]);
				tmp[0] = tmp[0] ^ rc;
				rc = gf_xtime(rc);
			end
			for (int j = 0; j < 4; j++)
				w[4 * i + j] = w[4 * (i - 4) + j] ^ tmp[j];
		end
		for (int i = 0; i < 16; i++)
			s[i] = pt[127 - 8 * i -: 8] ^ w[i];
		for (int r = 1; r <= NUM_ROUNDS; r++)
		begin
			// SubBytes and ShiftRows, row r rotated left by r
			for (int i = 0; i < 16; i++)
				t[i] = aes_sbox(s[4 * ((i / 4 + i % 4) % 4) + i % 4]);
			// MixColumns as 2a ^ 3b ^ c ^ d, none in the last round
			for (int i = 0; i < 16; i++)
			begin
				b = i - i % 4;
				if (r == NUM_ROUNDS)
					s[i] = t[i];
				else
					s[i] = gf_xtime(t[i]) ^ gf_xtime(t[b + (i + 1) % 4]) ^ t[b + (i + 1) % 4]
						^ t[b + (i + 2) % 4] ^ t[b + (i + 3) % 4];
			end
			for (int i = 0; i < 16; i++)
				s[i] = s[i] ^ w[16 * r + i];
		end
		for (int i = 0; i < 16; i++)
			ct[127 - 8 * i -: 8] = s[i];
		return ct;
	endfunction

	function automatic aes_block_t rand_block();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	task automatic check_value(string test_name, aes_block_t expected, aes_block_t actual);
		if (expected !== actual)
		begin
			$display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
			errors++;
		end
	endtask

	// ========================================================================
	// Clock, watchdog, comparing process, sink
	// ========================================================================

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(NUM_BLOCKS * 100 * CLK_PERIOD + 2000);
		$display("Timeout: the run did not finish, the DUT or the testbench hung");
		$display("*** TEST FAILED ***");
		$finish;
	end

	always @(negedge clk)
	begin
		if (rst_n)
		begin
			// Credit check uses only credits returned at earlier edges
			if (out_blk.valid)
			begin
				valid_total++;
				credits_owed++;
				outstanding--;
				if (valid_total > OUT_CREDITS + returned_total)
				begin
					$display("Output block sent without sink credit at %0t", $time);
					errors++;
				end
				if (exp_q.size() == 0)
				begin
					$display("Output block appeared with no block outstanding at %0t", $time);
					errors++;
				end
				else
					check_value(name_q.pop_front(), exp_q.pop_front(), out_blk.data);
			end
			if (out_credit)
				returned_total++;
			// One credit at a time, and only with nothing in flight
			if (in_credit)
			begin
				if (credits_held != 0 || outstanding != 0)
				begin
					$display("Input credit granted while a block was still held at %0t", $time);
					errors++;
				end
				credits_held++;
			end
		end
	end

	// Sink hands one credit back per result after 0 to 7 cycles
	initial
	begin
		out_credit = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			if (credits_owed > 0 && !hold_credit)
			begin
				sink_delay = $unsigned($random(seed)) % 8;
				repeat (sink_delay)
				begin
					@(posedge clk);
					#1;
				end
				out_credit = 1'b1;
				credits_owed--;
				@(posedge clk);
				#1;
				out_credit = 1'b0;
			end
		end
	end

	// ========================================================================
	// Host tasks, all entered 1 ns after a rising edge
	// ========================================================================

	task automatic wait_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_credit();
		while (credits_held == 0)
			wait_cycle();
	endtask

	task automatic send_block(string test_name, aes_block_t data, aes_block_t expected);
		wait_credit();
		in_blk.data  = data;
		in_blk.valid = 1'b1;
		credits_held--;
		outstanding++;
		exp_q.push_back(expected);
		name_q.push_back(test_name);
		wait_cycle();
		in_blk.valid = 1'b0;
	endtask

	// Holding a credit means the core is idle
	task automatic load_key(key_t k, aes_mode_t m);
		wait_credit();
		key      = k;
		mode     = m;
		key_load = 1'b1;
		cur_key  = k;
		wait_cycle();
		key_load = 1'b0;
	endtask

	task automatic load_iv(aes_block_t v);
		wait_credit();
		iv        = v;
		iv_load   = 1'b1;
		ctr_model = v;
		wait_cycle();
		iv_load = 1'b0;
	endtask

	task automatic send_ctr(aes_block_t data);
		send_block("ctr", data, data ^ aes_encrypt_ref(cur_key, ctr_model));
		// Wraps modulo 2^128 like the core
		ctr_model = ctr_model + 128'd1;
	endtask

	task automatic drain();
		while (outstanding != 0 || credits_owed != 0 || out_credit)
			wait_cycle();
	endtask

	// Scoreboard and credit books restart with the DUT
	task automatic apply_reset();
		rst_n = 1'b0;
		exp_q.delete();
		name_q.delete();
		credits_held   = 0;
		outstanding    = 0;
		credits_owed   = 0;
		valid_total    = 0;
		returned_total = 0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial
	begin
		key_load = 1'b0;
		key      = '0;
		mode     = ECB;
		iv_load  = 1'b0;
		iv       = '0;
		in_blk   = '0;
		apply_reset();

		// FIPS-197 appendix C.1
		load_key(128'h000102030405060708090a0b0c0d0e0f, ECB);
		send_block("fips197_ecb", 128'h00112233445566778899aabbccddeeff,
			128'h69c4e0d86a7b0430d8cdb78070b4c55a);

		// Random ECB, new key every fifth block
		for (int i = 0; i < 20; i++)
		begin
			if (i % 5 == 0)
				load_key(rand_block(), ECB);
			data_tmp = rand_block();
			send_block("ecb_random", data_tmp, aes_encrypt_ref(cur_key, data_tmp));
		end

		// CTR, then an all-ones IV that wraps to zero
		load_key(rand_block(), CTR);
		load_iv(rand_block());
		repeat (3)
			send_ctr(rand_block());
		load_iv('1);
		repeat (2)
			send_ctr(rand_block());

		// Sink withholds credit for a while
		load_key(rand_block(), ECB);
		drain();
		hold_credit = 1'b1;
		fork
			begin
				repeat (4)
				begin
					data_tmp = rand_block();
					send_block("backpressure", data_tmp, aes_encrypt_ref(cur_key, data_tmp));
				end
			end
			begin
				repeat (400) @(posedge clk);
				#1;
				hold_credit = 1'b0;
			end
		join
		drain();

		// Reset in the middle of a block, that block must never come out
		load_key(rand_block(), ECB);
		data_tmp = rand_block();
		send_block("reset_abort", data_tmp, aes_encrypt_ref(cur_key, data_tmp));
		repeat (20)
			wait_cycle();
		apply_reset();
		load_key(rand_block(), ECB);
		data_tmp = rand_block();
		send_block("after_reset", data_tmp, aes_encrypt_ref(cur_key, data_tmp));
		drain();
		repeat (10)
			wait_cycle();

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
